// File: common/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] xlen_t;

    // major opcodes of the supported subset.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    localparam logic MEM_BYTE = 1'b0;
    localparam logic MEM_WORD = 1'b1;

    localparam xlen_t EBREAK_WORD = 32'h0010_0073;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } rv_s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } rv_b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_fmt_t;

    // one instruction word, seen through each encoding format.
    typedef union packed {
        rv_r_fmt_t r_fmt;
        rv_i_fmt_t i_fmt;
        rv_s_fmt_t s_fmt;
        rv_b_fmt_t b_fmt;
        rv_u_fmt_t u_fmt;
        rv_j_fmt_t j_fmt;
    } rv_inst_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    reg_we;
        logic    mem_ren;
        logic    mem_wen;
        logic    mem_size;
        logic    mem_unsigned;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jal;
        logic    is_ebreak;
        logic    illegal;
    } rv_ctrl_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        xlen_t      addr;
        xlen_t      wdata;
        logic [3:0] wmask;
    } rv_dmem_req_t;

endpackage

// File: rtl/rv_sram.sv
`timescale 1ns/1ps

module rv_sram import rv_pkg::*; #(
    parameter int WORDS = 64
) (
    input  logic       clk,
    input  logic       ren_i,
    input  logic       wen_i,
    input  xlen_t      raddr_i,
    input  xlen_t      waddr_i,
    input  xlen_t      wdata_i,
    input  logic [3:0] wmask_i,
    output xlen_t      rdata_o
);

    localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1;

    xlen_t         mem [WORDS];
    logic [AW-1:0] ridx;
    logic [AW-1:0] widx;

    // word index wraps at the memory depth.
    assign ridx = AW'(raddr_i[31:2] % WORDS);
    assign widx = AW'(waddr_i[31:2] % WORDS);

    assign rdata_o = ren_i ? mem[ridx] : '0;

    always_ff @(posedge clk) begin
        if (wen_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask_i[b]) begin
                    mem[widx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: cpu/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
    input  rv_inst_u inst_i,
    output rv_ctrl_t ctrl_o,
    output xlen_t    imm_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = inst_i.r_fmt.funct3;
    assign funct7 = inst_i.r_fmt.funct7;

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = ALU_ADD;
        imm_o         = '0;
        case (rv_opcode_e'(inst_i.r_fmt.opcode))
            OPC_OP: begin
                ctrl_o.reg_we = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl_o.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl_o.alu_op = ALU_SUB;
                    {7'b0000000, 3'b010}: ctrl_o.alu_op = ALU_SLT;
                    {7'b0000000, 3'b100}: ctrl_o.alu_op = ALU_XOR;
                    {7'b0000000, 3'b110}: ctrl_o.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: ctrl_o.alu_op = ALU_AND;
                    default:              ctrl_o.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                imm_o              = {{20{inst_i.i_fmt.imm_11_0[11]}}, inst_i.i_fmt.imm_11_0};
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_we      = 1'b1;
                ctrl_o.illegal     = (funct3 != 3'b000); // addi only.
            end
            OPC_LUI: begin
                imm_o              = {inst_i.u_fmt.imm_31_12, 12'b0};
                ctrl_o.alu_op      = ALU_PASS_B;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_we      = 1'b1;
            end
            OPC_LOAD: begin
                imm_o              = {{20{inst_i.i_fmt.imm_11_0[11]}}, inst_i.i_fmt.imm_11_0};
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_we      = 1'b1;
                ctrl_o.mem_ren     = 1'b1;
                ctrl_o.mem_size    = (funct3 == 3'b010) ? MEM_WORD : MEM_BYTE;
                ctrl_o.mem_unsigned = (funct3 == 3'b100);
                ctrl_o.illegal     = !(funct3 inside {3'b000, 3'b010, 3'b100});
            end
            OPC_STORE: begin
                imm_o              = {{20{inst_i.s_fmt.imm_11_5[6]}},
                                      inst_i.s_fmt.imm_11_5, inst_i.s_fmt.imm_4_0};
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_wen     = 1'b1;
                ctrl_o.mem_size    = (funct3 == 3'b010) ? MEM_WORD : MEM_BYTE;
                ctrl_o.illegal     = !(funct3 inside {3'b000, 3'b010});
            end
            OPC_BRANCH: begin
                imm_o            = {{19{inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_12,
                                    inst_i.b_fmt.imm_11, inst_i.b_fmt.imm_10_5,
                                    inst_i.b_fmt.imm_4_1, 1'b0};
                ctrl_o.alu_op    = ALU_SUB;
                ctrl_o.is_branch = 1'b1;
                ctrl_o.branch_ne = funct3[0]; // bne.
                ctrl_o.illegal   = !(funct3 inside {3'b000, 3'b001});
            end
            OPC_JAL: begin
                imm_o         = {{11{inst_i.j_fmt.imm_20}}, inst_i.j_fmt.imm_20,
                                 inst_i.j_fmt.imm_19_12, inst_i.j_fmt.imm_11,
                                 inst_i.j_fmt.imm_10_1, 1'b0};
                ctrl_o.reg_we = 1'b1;
                ctrl_o.is_jal = 1'b1;
            end
            OPC_SYSTEM: begin
                // only the exact ebreak word is accepted
                ctrl_o.is_ebreak = (inst_i == EBREAK_WORD);
                ctrl_o.illegal   = (inst_i != EBREAK_WORD);
            end
            default: ctrl_o.illegal = 1'b1;
        endcase
    end

endmodule

// File: cpu/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic [4:0] rs1_i,
    input  logic [4:0] rs2_i,
    input  logic [4:0] rd_i,
    input  logic       we_i,
    input  xlen_t      wdata_i,
    output xlen_t      rdata1_o,
    output xlen_t      rdata2_o
);

    xlen_t regs [1:31]; // x0 has no storage.

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != 5'd0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

// File: cpu/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  alu_op_e op_i,
    input  xlen_t   a_i,
    input  xlen_t   b_i,
    output xlen_t   result_o,
    output logic    equal_o
);

    logic less_signed;

    assign less_signed = ($signed(a_i) < $signed(b_i));

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_OR:     result_o = a_i | b_i;
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SLT:    result_o = {31'b0, less_signed};
            ALU_PASS_B: result_o = b_i; // lui.
            default:    result_o = '0;
        endcase
    end

    assign equal_o = (a_i == b_i); // beq and bne.

endmodule

// File: cpu/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic         clk,
    input  logic         rst_n_i,
    output xlen_t        imem_addr_o,
    input  xlen_t        imem_rdata_i,
    output rv_dmem_req_t dmem_req_o,
    input  xlen_t        dmem_rdata_i,
    output logic         finish_o,
    output logic         invalid_o,
    output xlen_t        exit_code_o
);

    xlen_t    pc_q;
    rv_inst_u inst;
    rv_ctrl_t ctrl;
    xlen_t    imm;
    logic     halted;
    logic     active;
    logic [4:0] rs1_addr;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    alu_b;
    xlen_t    alu_result;
    logic     alu_equal;
    xlen_t    pc_plus4;
    xlen_t    pc_target;
    logic     branch_taken;
    xlen_t    pc_next;
    logic [7:0] load_byte;
    xlen_t    load_data;
    xlen_t    wb_data;

    assign inst        = rv_inst_u'(imem_rdata_i);
    assign imem_addr_o = pc_q;

    rv_decoder u_decoder (
        .inst_i (inst),
        .ctrl_o (ctrl),
        .imm_o  (imm)
    );

    assign halted = finish_o | invalid_o;
    assign active = !halted && !ctrl.illegal; // only legal, running instructions write.

    // ebreak borrows read port 1 to fetch a0.
    assign rs1_addr = ctrl.is_ebreak ? 5'd10 : inst.r_fmt.rs1;

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .rs1_i    (rs1_addr),
        .rs2_i    (inst.r_fmt.rs2),
        .rd_i     (inst.r_fmt.rd),
        .we_i     (active && ctrl.reg_we),
        .wdata_i  (wb_data),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    assign alu_b = ctrl.alu_src_imm ? imm : rs2_data;

    rv_alu u_alu (
        .op_i     (ctrl.alu_op),
        .a_i      (rs1_data),
        .b_i      (alu_b),
        .result_o (alu_result),
        .equal_o  (alu_equal)
    );

    // data memory request, alu sum is the address.
    always_comb begin
        dmem_req_o.ren  = active && ctrl.mem_ren;
        dmem_req_o.wen  = active && ctrl.mem_wen;
        dmem_req_o.addr = alu_result;
        if (ctrl.mem_size == MEM_WORD) begin
            dmem_req_o.wdata = rs2_data;
            dmem_req_o.wmask = 4'b1111;
        end else begin
            dmem_req_o.wdata = {4{rs2_data[7:0]}}; // byte on every lane.
            dmem_req_o.wmask = 4'b0001 << alu_result[1:0];
        end
    end

    assign load_byte = dmem_rdata_i[{alu_result[1:0], 3'b000} +: 8];

    always_comb begin
        if (ctrl.mem_size == MEM_WORD) begin
            load_data = dmem_rdata_i;
        end else if (ctrl.mem_unsigned) begin
            load_data = {24'b0, load_byte};
        end else begin
            load_data = {{24{load_byte[7]}}, load_byte};
        end
    end

    assign pc_plus4     = pc_q + 32'd4;
    assign pc_target    = pc_q + imm;
    assign branch_taken = ctrl.is_branch && (alu_equal ^ ctrl.branch_ne);
    assign pc_next      = (ctrl.is_jal || branch_taken) ? pc_target : pc_plus4;

    assign wb_data = ctrl.is_jal  ? pc_plus4  :
                     ctrl.mem_ren ? load_data : alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q      <= RESET_PC;
            finish_o  <= 1'b0;
            invalid_o <= 1'b0;
        end else if (!halted) begin
            if (ctrl.illegal) begin
                invalid_o <= 1'b1; // pc stays on the bad word.
            end else if (ctrl.is_ebreak) begin
                finish_o <= 1'b1;
            end else begin
                pc_q <= pc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!halted && ctrl.is_ebreak) begin
            exit_code_o <= rs1_data; // a0 at ebreak.
        end
    end

endmodule

// File: rtl/rv_soc.sv
`timescale 1ns/1ps

module rv_soc import rv_pkg::*; #(
    parameter int    IMEM_WORDS = 64,
    parameter int    DMEM_WORDS = 64,
    parameter xlen_t RESET_PC   = '0
) (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  load_we_i,
    input  xlen_t load_addr_i,
    input  xlen_t load_data_i,
    output xlen_t pc_o,
    output logic  finish_o,
    output logic  invalid_o,
    output xlen_t exit_code_o
);

    xlen_t        inst;
    rv_dmem_req_t dmem_req;
    xlen_t        dmem_rdata;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) u_core (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .imem_addr_o  (pc_o),
        .imem_rdata_i (inst),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata),
        .finish_o     (finish_o),
        .invalid_o    (invalid_o),
        .exit_code_o  (exit_code_o)
    );

    // instruction memory, written only by the loader.
    rv_sram #(
        .WORDS (IMEM_WORDS)
    ) u_inst_sram (
        .clk     (clk),
        .ren_i   (1'b1),
        .wen_i   (load_we_i),
        .raddr_i (pc_o),
        .waddr_i (load_addr_i),
        .wdata_i (load_data_i),
        .wmask_i (4'b1111),
        .rdata_o (inst)
    );

    rv_sram #(
        .WORDS (DMEM_WORDS)
    ) u_data_sram (
        .clk     (clk),
        .ren_i   (dmem_req.ren),
        .wen_i   (dmem_req.wen),
        .raddr_i (dmem_req.addr),
        .waddr_i (dmem_req.addr),
        .wdata_i (dmem_req.wdata),
        .wmask_i (dmem_req.wmask),
        .rdata_o (dmem_rdata)
    );

endmodule

// File: testbench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NUM_TESTS  = 6;
localparam int PROG_WORDS = 16;

string test_name        [NUM_TESTS];
xlen_t program_words    [NUM_TESTS][PROG_WORDS];
int    program_len      [NUM_TESTS];
xlen_t expected_exit    [NUM_TESTS];
logic  expected_invalid [NUM_TESTS];
xlen_t expected_pc      [NUM_TESTS];

function automatic xlen_t r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                 logic [2:0] f3, logic [4:0] rd);
    rv_inst_u w;
    w.r_fmt = '{f7, rs2, rs1, f3, rd, OPC_OP};
    return w;
endfunction

function automatic xlen_t i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                 logic [4:0] rd, rv_opcode_e opc);
    rv_inst_u w;
    w.i_fmt = '{imm, rs1, f3, rd, opc};
    return w;
endfunction

function automatic xlen_t s_word(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                 logic [2:0] f3);
    rv_inst_u w;
    w.s_fmt = '{imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    return w;
endfunction

function automatic xlen_t b_word(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                 logic [2:0] f3);
    rv_inst_u w;
    w.b_fmt = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    return w;
endfunction

function automatic xlen_t u_word(logic [19:0] imm, logic [4:0] rd);
    rv_inst_u w;
    w.u_fmt = '{imm, rd, OPC_LUI};
    return w;
endfunction

function automatic xlen_t j_word(logic [20:0] off, logic [4:0] rd);
    rv_inst_u w;
    w.j_fmt = '{off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    return w;
endfunction

function automatic void add_word(int t, xlen_t w);
    program_words[t][program_len[t]] = w;
    program_len[t]++;
endfunction

function automatic void build_tests();
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    xlen_t       va;
    xlen_t       vb;
    xlen_t       mix;
    xlen_t       slt_v;
    for (int t = 0; t < NUM_TESTS; t++) begin
        program_len[t] = 0;
        for (int w = 0; w < PROG_WORDS; w++) begin
            program_words[t][w] = '0; // all-zero word is illegal.
        end
    end

    imm_a = 12'(random_bits(12));
    imm_b = 12'(random_bits(12));
    test_name[0] = "arith";
    add_word(0, i_word(imm_a, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    add_word(0, i_word(imm_b, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
    add_word(0, r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3)); // add.
    add_word(0, r_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4)); // sub.
    add_word(0, r_word(7'h00, 5'd4, 5'd3, 3'b111, 5'd5)); // and.
    add_word(0, r_word(7'h00, 5'd1, 5'd5, 3'b110, 5'd6)); // or.
    add_word(0, r_word(7'h00, 5'd2, 5'd6, 3'b100, 5'd7)); // xor.
    add_word(0, r_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd8)); // slt.
    add_word(0, u_word(20'h12345, 5'd9));
    add_word(0, r_word(7'h00, 5'd8, 5'd7, 3'b000, 5'd10));
    add_word(0, r_word(7'h00, 5'd9, 5'd10, 3'b100, 5'd10));
    add_word(0, EBREAK_WORD);
    va    = {{20{imm_a[11]}}, imm_a};
    vb    = {{20{imm_b[11]}}, imm_b};
    mix   = (((va + vb) & (va - vb)) | va) ^ vb;
    slt_v = ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0;
    expected_exit[0]    = (mix + slt_v) ^ 32'h1234_5000;
    expected_invalid[0] = 1'b0;
    expected_pc[0]      = 32'd44;

    test_name[1] = "memory";
    add_word(1, u_word(20'h11223, 5'd1));
    add_word(1, i_word(12'h344, 5'd1, 3'b000, 5'd1, OPC_OP_IMM));
    add_word(1, s_word(12'd8, 5'd1, 5'd0, 3'b010)); // sw.
    add_word(1, i_word(12'd8, 5'd0, 3'b010, 5'd2, OPC_LOAD));
    add_word(1, i_word(-12'd128, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
    add_word(1, s_word(12'd10, 5'd3, 5'd0, 3'b000)); // sb to byte 2.
    add_word(1, i_word(12'd8, 5'd0, 3'b010, 5'd4, OPC_LOAD));
    add_word(1, i_word(12'd10, 5'd0, 3'b000, 5'd5, OPC_LOAD)); // lb.
    add_word(1, i_word(12'd10, 5'd0, 3'b100, 5'd6, OPC_LOAD)); // lbu.
    add_word(1, r_word(7'h20, 5'd1, 5'd2, 3'b000, 5'd7));
    add_word(1, r_word(7'h00, 5'd2, 5'd4, 3'b100, 5'd10));
    add_word(1, r_word(7'h00, 5'd7, 5'd10, 3'b000, 5'd10));
    add_word(1, r_word(7'h20, 5'd5, 5'd6, 3'b000, 5'd8));
    add_word(1, r_word(7'h00, 5'd8, 5'd10, 3'b000, 5'd10));
    add_word(1, EBREAK_WORD);
    // only byte 2 changes to 80, lbu minus lb is 0x100.
    expected_exit[1]    = (32'h1180_3344 ^ 32'h1122_3344) + (32'h0000_0080 - 32'hffff_ff80);
    expected_invalid[1] = 1'b0;
    expected_pc[1]      = 32'd56;

    test_name[2] = "branch";
    add_word(2, i_word(12'd10, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    add_word(2, i_word(12'd0, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
    add_word(2, r_word(7'h00, 5'd1, 5'd10, 3'b000, 5'd10));
    add_word(2, i_word(-12'd1, 5'd1, 3'b000, 5'd1, OPC_OP_IMM));
    add_word(2, b_word(-13'd8, 5'd0, 5'd1, 3'b001)); // bne back to the add.
    add_word(2, b_word(13'd8, 5'd0, 5'd10, 3'b000)); // beq, not taken.
    add_word(2, EBREAK_WORD);
    add_word(2, i_word(12'd1, 5'd10, 3'b000, 5'd10, OPC_OP_IMM));
    add_word(2, EBREAK_WORD);
    expected_exit[2]    = 32'd55;
    expected_invalid[2] = 1'b0;
    expected_pc[2]      = 32'd24;

    test_name[3] = "jal";
    add_word(3, i_word(12'd7, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
    add_word(3, j_word(21'd8, 5'd1));
    add_word(3, i_word(12'd99, 5'd0, 3'b000, 5'd2, OPC_OP_IMM)); // skipped.
    add_word(3, i_word(-12'd3, 5'd1, 3'b000, 5'd10, OPC_OP_IMM));
    add_word(3, r_word(7'h00, 5'd2, 5'd10, 3'b000, 5'd10));
    add_word(3, EBREAK_WORD);
    expected_exit[3]    = 32'd8 - 32'd3 + 32'd7; // link is 8.
    expected_invalid[3] = 1'b0;
    expected_pc[3]      = 32'd20;

    test_name[4] = "x0";
    add_word(4, i_word(12'd77, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
    add_word(4, i_word(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    add_word(4, i_word(12'd123, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
    add_word(4, r_word(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
    add_word(4, u_word(20'hfffff, 5'd0));
    add_word(4, j_word(21'd4, 5'd0));
    add_word(4, r_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd10));
    add_word(4, EBREAK_WORD);
    expected_exit[4]    = 32'd0;
    expected_invalid[4] = 1'b0;
    expected_pc[4]      = 32'd28;

    test_name[5] = "illegal";
    add_word(5, i_word(12'd42, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
    add_word(5, i_word(12'd1, 5'd10, 3'b000, 5'd10, OPC_OP_IMM));
    add_word(5, 32'h0000_0000);
    add_word(5, EBREAK_WORD);
    expected_exit[5]    = 32'd0; // not checked.
    expected_invalid[5] = 1'b1;
    expected_pc[5]      = 32'd8;
endfunction

`endif

// File: testbench/tb_rv_soc.sv
`timescale 1ns/1ps

module tb_rv_soc import rv_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 500;
    localparam int RESET_CYCLES   = 16;

    logic  clk;
    logic  rst_n;
    logic  load_we;
    xlen_t load_addr;
    xlen_t load_data;
    xlen_t pc;
    logic  finish;
    logic  invalid;
    xlen_t exit_code;
    xlen_t lfsr_state = 32'hf7fa;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit.
    function automatic xlen_t random_bits(int n);
        xlen_t bits;
        logic  fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {fb, lfsr_state[31:1]};
        end
        return bits;
    endfunction

`include "tb_programs.svh"

    // imem holds exactly one program, loaded in the reset window.
    rv_soc #(
        .IMEM_WORDS (PROG_WORDS),
        .DMEM_WORDS (64),
        .RESET_PC   (32'h0)
    ) UUT (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .load_we_i   (load_we),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .pc_o        (pc),
        .finish_o    (finish),
        .invalid_o   (invalid),
        .exit_code_o (exit_code)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(string name, string what, xlen_t expected, xlen_t actual);
        if (actual !== expected) begin
            $display("Mismatch in test %s, %s: expected %h, actual %h",
                     name, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_flag(string name, string what, logic expected, logic actual);
        if (actual !== expected) begin
            $display("Mismatch in test %s, %s: expected %b, actual %b",
                     name, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic reset_and_load(int t);
        for (int i = 0; i < RESET_CYCLES; i++) begin
            next_cycle();
            rst_n     = 1'b0;
            load_we   = 1'b1;
            load_addr = xlen_t'(i * 4);
            load_data = program_words[t][i % PROG_WORDS];
        end
        next_cycle();
        rst_n   = 1'b1;
        load_we = 1'b0;
    endtask

    task automatic run_to_halt(int t);
        int cycles;
        cycles = 0;
        while (!finish && !invalid) begin
            if (cycles == TIMEOUT_CYCLES) begin
                $display("Test %s did not halt within %0d cycles", test_name[t],
                         TIMEOUT_CYCLES);
                $display("Simulation failed");
                $fatal(1, "timeout");
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic check_outcome(int t);
        check_flag(test_name[t], "invalid_o", expected_invalid[t], invalid);
        check_flag(test_name[t], "finish_o", !expected_invalid[t], finish);
        check_word(test_name[t], "pc_o", expected_pc[t], pc);
        if (!expected_invalid[t]) begin
            check_word(test_name[t], "exit_code_o", expected_exit[t], exit_code);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_tests();
        for (int t = 0; t < NUM_TESTS; t++) begin
            reset_and_load(t);
            run_to_halt(t);
            check_outcome(t);
            repeat (3) next_cycle();
            check_outcome(t); // halted state holds.
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+testbench
common/rv_pkg.sv
rtl/rv_sram.sv
cpu/rv_decoder.sv
cpu/rv_regfile.sv
cpu/rv_alu.sv
cpu/rv_core.sv
rtl/rv_soc.sv
testbench/tb_rv_soc.sv
